/* hdl/md_loader_pkg.sv */
// Cartridge loader shared types
// Region, download kinds and pipeline records
`default_nettype none

package md_loader_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Enumerations
	////////////////////////////////////////////////////////////////////////////

	// Console region, encoded as the core expects it
	typedef enum logic [1:0] {
		REGION_JP = 2'd0,
		REGION_US = 2'd1,
		REGION_EU = 2'd2
	} region_t;

	// What the host is currently sending
	typedef enum logic [1:0] {
		DL_NONE     = 2'd0,
		DL_MD_CART  = 2'd1,
		DL_SMS_CART = 2'd2,
		DL_CHEAT    = 2'd3
	} dl_kind_t;

	// Auto region source, last code acts as disabled
	typedef enum logic [1:0] {
		RM_HEADER    = 2'd0,
		RM_FILE_EXT  = 2'd1,
		RM_DISABLED  = 2'd2,
		RM_DISABLED2 = 2'd3
	} region_mode_t;

	// Search order for header region letters
	typedef enum logic [1:0] {
		PRIO_US_EU_JP = 2'd0,
		PRIO_EU_US_JP = 2'd1,
		PRIO_US_JP_EU = 2'd2,
		PRIO_JP_US_EU = 2'd3
	} region_prio_t;

	////////////////////////////////////////////////////////////////////////////
	// Constants
	////////////////////////////////////////////////////////////////////////////

	localparam int DL_ADDR_W = 25;

	// Word addresses in the Mega Drive header
	localparam int unsigned HDR_REGION_ADDR  = 32'h1F0;
	localparam int unsigned HDR_REGION2_ADDR = 32'h1F2;
	localparam int unsigned HDR_END_ADDR     = 32'h200;

	////////////////////////////////////////////////////////////////////////////
	// Records passed between stages
	////////////////////////////////////////////////////////////////////////////

	// One registered download beat
	typedef struct packed {
		dl_kind_t               kind;
		logic                   wr;
		logic                   start;
		logic                   finish;
		logic [1:0]             ext;
		logic [DL_ADDR_W-1:0]   addr;
		logic [15:0]            data;
	} dl_beat_t;

	// Region flags found in the header
	typedef struct packed {
		logic       hdr_j;
		logic       hdr_u;
		logic       hdr_e;
		logic       ready;
		logic [1:0] ext;
	} hdr_info_t;

	// Cheat entry, words kept big endian as loaded
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

endpackage

`default_nettype wire

/* hdl/dl_classify.sv */
// Download beat classifier
`default_nettype none

module dl_classify #(
	parameter int ADDR_W = md_loader_pkg::DL_ADDR_W
) (
	input  wire                     clk_sys,
	input  wire                     sys_reset,
	input  wire                     dl_active_i,
	input  wire  [7:0]              dl_index_i,
	input  wire                     dl_wr_i,
	input  wire  [ADDR_W-1:0]       dl_addr_i,
	input  wire  [15:0]             dl_data_i,
	output md_loader_pkg::dl_beat_t beat_o,
	output logic                    cart_ms_o
);

	localparam int BEAT_AW = md_loader_pkg::DL_ADDR_W;

	logic                    active_q;
	logic                    start_d;
	logic                    finish_d;
	md_loader_pkg::dl_kind_t index_kind;
	md_loader_pkg::dl_kind_t kind_d;
	md_loader_pkg::dl_kind_t kind_q;
	md_loader_pkg::dl_kind_t beat_kind_q;
	logic                    wr_q;
	logic                    start_q;
	logic                    finish_q;
	logic [1:0]              ext_q;
	logic [BEAT_AW-1:0]      addr_q;
	logic [15:0]             data_q;

	function automatic md_loader_pkg::dl_kind_t decode_index(input logic [7:0] index);
		if (&index)
			return md_loader_pkg::DL_CHEAT;
		if (index[4:0] == 5'd1)
			return md_loader_pkg::DL_MD_CART;
		if (index[4:0] == 5'd2)
			return md_loader_pkg::DL_SMS_CART;
		return md_loader_pkg::DL_NONE;
	endfunction

	assign index_kind = decode_index(dl_index_i);
	assign start_d    = dl_active_i & ~active_q;
	assign finish_d   = ~dl_active_i & active_q;

	// Finish beat keeps the kind of the download it closes
	assign kind_d = dl_active_i ? index_kind :
		(active_q ? kind_q : md_loader_pkg::DL_NONE);

	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			active_q    <= 1'b0;
			kind_q      <= md_loader_pkg::DL_NONE;
			beat_kind_q <= md_loader_pkg::DL_NONE;
			wr_q        <= 1'b0;
			start_q     <= 1'b0;
			finish_q    <= 1'b0;
			cart_ms_o   <= 1'b0;
		end else begin
			active_q    <= dl_active_i;
			beat_kind_q <= kind_d;
			wr_q        <= dl_wr_i & dl_active_i;
			start_q     <= start_d;
			finish_q    <= finish_d;
			if (dl_active_i)
				kind_q <= index_kind;
			// Console type of the last cartridge
			if (start_d && index_kind == md_loader_pkg::DL_SMS_CART)
				cart_ms_o <= 1'b1;
			else if (start_d && index_kind == md_loader_pkg::DL_MD_CART)
				cart_ms_o <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		ext_q  <= dl_index_i[7:6];
		addr_q <= BEAT_AW'(dl_addr_i);
		data_q <= dl_data_i;
	end

	assign beat_o = '{
		kind:   beat_kind_q,
		wr:     wr_q,
		start:  start_q,
		finish: finish_q,
		ext:    ext_q,
		addr:   addr_q,
		data:   data_q
	};

endmodule

`default_nettype wire

/* hdl/hdr_region_scan.sv */
// Cartridge header region scanner
`default_nettype none

module hdr_region_scan #(
	parameter int ADDR_W = md_loader_pkg::DL_ADDR_W
) (
	input  wire                      clk_sys,
	input  wire                      sys_reset,
	input  wire md_loader_pkg::dl_beat_t beat_i,
	output md_loader_pkg::hdr_info_t hdr_o
);

	localparam logic [ADDR_W-1:0] REGION_ADDR  = ADDR_W'(md_loader_pkg::HDR_REGION_ADDR);
	localparam logic [ADDR_W-1:0] REGION2_ADDR = ADDR_W'(md_loader_pkg::HDR_REGION2_ADDR);
	localparam logic [ADDR_W-1:0] END_ADDR     = ADDR_W'(md_loader_pkg::HDR_END_ADDR);

	logic [ADDR_W-1:0] addr;
	logic              cart_beat;
	logic              cart_wr;
	logic [7:0]        lo_byte;
	logic [7:0]        hi_byte;
	logic [3:0]        hex_nib;
	logic [2:0]        lo_letter;
	logic [2:0]        hi_letter;
	// Flags held as {e, u, j}
	logic [2:0]        flags_d;
	logic [2:0]        flags_q;
	logic              ready_d;
	logic              ready_q;
	logic [1:0]        ext_q;

	// One-hot {e, u, j} for a region letter
	function automatic logic [2:0] letter_flags(input logic [7:0] ch);
		case (ch)
			"J":     return 3'b001;
			"U":     return 3'b010;
			"E":     return 3'b100;
			default: return 3'b000;
		endcase
	endfunction

	assign addr      = ADDR_W'(beat_i.addr);
	assign cart_beat = (beat_i.kind == md_loader_pkg::DL_MD_CART) ||
		(beat_i.kind == md_loader_pkg::DL_SMS_CART);
	assign cart_wr   = cart_beat & beat_i.wr;
	assign lo_byte   = beat_i.data[7:0];
	assign hi_byte   = beat_i.data[15:8];
	assign lo_letter = letter_flags(lo_byte);
	assign hi_letter = letter_flags(hi_byte);
	// Hex digits A to F land on the same bits as 0 to 9
	assign hex_nib   = beat_i.data[3:0] - 4'd7;

	always_comb begin
		flags_d = flags_q;
		ready_d = ready_q;
		if (cart_beat && beat_i.start)
			flags_d = 3'b000;
		if (cart_beat && beat_i.finish)
			ready_d = 1'b0;
		if (cart_wr && addr == REGION_ADDR) begin
			if (|lo_letter)
				flags_d = flags_d | lo_letter;
			else if (lo_byte >= "0" && lo_byte <= "9")
				flags_d = {lo_byte[3], lo_byte[2], lo_byte[0]};
			else if (lo_byte >= "A" && lo_byte <= "F")
				flags_d = {hex_nib[3], hex_nib[2], hex_nib[0]};
			// High byte only adds letters
			flags_d = flags_d | hi_letter;
		end
		if (cart_wr && addr == REGION2_ADDR)
			flags_d = flags_d | lo_letter;
		if (cart_wr && addr == END_ADDR)
			ready_d = 1'b1;
	end

	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			flags_q <= 3'b000;
			ready_q <= 1'b0;
			ext_q   <= 2'b00;
		end else begin
			flags_q <= flags_d;
			ready_q <= ready_d;
			if (cart_beat)
				ext_q <= beat_i.ext;
		end
	end

	assign hdr_o = '{
		hdr_j: flags_q[0],
		hdr_u: flags_q[1],
		hdr_e: flags_q[2],
		ready: ready_q,
		ext:   ext_q
	};

endmodule

`default_nettype wire

/* hdl/region_select.sv */
// Automatic region selection
`default_nettype none

module region_select (
	input  wire                              clk_sys,
	input  wire                              sys_reset,
	input  wire md_loader_pkg::hdr_info_t    hdr_i,
	input  wire                              cart_ms_i,
	input  wire md_loader_pkg::region_mode_t region_mode_i,
	input  wire md_loader_pkg::region_prio_t region_prio_i,
	output md_loader_pkg::region_t           region_o,
	output logic                             region_set_o
);

	logic                   ready_q;
	logic                   ready_rise;
	logic                   ready_fall;
	md_loader_pkg::region_t hdr_region;

	// First flag found in priority order or the head of the order when none
	function automatic md_loader_pkg::region_t pick_region(
		input md_loader_pkg::region_prio_t prio,
		input logic                        j,
		input logic                        u,
		input logic                        e
	);
		case (prio)
			md_loader_pkg::PRIO_US_EU_JP: begin
				if (u) return md_loader_pkg::REGION_US;
				if (e) return md_loader_pkg::REGION_EU;
				if (j) return md_loader_pkg::REGION_JP;
				return md_loader_pkg::REGION_US;
			end
			md_loader_pkg::PRIO_EU_US_JP: begin
				if (e) return md_loader_pkg::REGION_EU;
				if (u) return md_loader_pkg::REGION_US;
				if (j) return md_loader_pkg::REGION_JP;
				return md_loader_pkg::REGION_EU;
			end
			md_loader_pkg::PRIO_US_JP_EU: begin
				if (u) return md_loader_pkg::REGION_US;
				if (j) return md_loader_pkg::REGION_JP;
				if (e) return md_loader_pkg::REGION_EU;
				return md_loader_pkg::REGION_US;
			end
			default: begin
				if (j) return md_loader_pkg::REGION_JP;
				if (u) return md_loader_pkg::REGION_US;
				if (e) return md_loader_pkg::REGION_EU;
				return md_loader_pkg::REGION_JP;
			end
		endcase
	endfunction

	assign hdr_region = pick_region(region_prio_i, hdr_i.hdr_j, hdr_i.hdr_u, hdr_i.hdr_e);
	assign ready_rise = hdr_i.ready & ~ready_q;
	assign ready_fall = ~hdr_i.ready & ready_q;

	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			ready_q      <= 1'b0;
			region_o     <= md_loader_pkg::REGION_JP;
			region_set_o <= 1'b0;
		end else begin
			ready_q <= hdr_i.ready;
			// Master System carts carry no usable header
			if (ready_rise && !cart_ms_i) begin
				case (region_mode_i)
					md_loader_pkg::RM_HEADER: begin
						region_set_o <= 1'b1;
						region_o     <= hdr_region;
					end
					md_loader_pkg::RM_FILE_EXT: begin
						region_set_o <= |hdr_i.ext;
						region_o     <= md_loader_pkg::region_t'(hdr_i.ext);
					end
					md_loader_pkg::RM_DISABLED,
					md_loader_pkg::RM_DISABLED2: begin
						region_set_o <= region_set_o;
					end
				endcase
			end
			if (ready_fall)
				region_set_o <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* hdl/cheat_code_assembler.sv */
// Cheat entry assembler
`default_nettype none

module cheat_code_assembler (
	input  wire                          clk_sys,
	input  wire                          sys_reset,
	input  wire md_loader_pkg::dl_beat_t beat_i,
	output md_loader_pkg::cheat_code_t   code_o,
	output logic                         strobe_o,
	output logic                         clear_o
);

	logic                       cheat_wr;
	logic                       cart_start;
	logic [3:0]                 offset;
	md_loader_pkg::cheat_code_t code_q;

	assign cheat_wr   = beat_i.wr && (beat_i.kind == md_loader_pkg::DL_CHEAT);
	assign cart_start = beat_i.start && ((beat_i.kind == md_loader_pkg::DL_MD_CART) ||
		(beat_i.kind == md_loader_pkg::DL_SMS_CART));
	assign offset     = beat_i.addr[3:0];

	////////////////////////////////////////////////////////////////////////////
	// Word placement, eight 16-bit words per entry
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (cheat_wr) begin
			case (offset)
				4'd0:  code_q.flags[15:0]    <= beat_i.data;
				4'd2:  code_q.flags[31:16]   <= beat_i.data;
				4'd4:  code_q.addr[15:0]     <= beat_i.data;
				4'd6:  code_q.addr[31:16]    <= beat_i.data;
				4'd8:  code_q.compare[15:0]  <= beat_i.data;
				4'd10: code_q.compare[31:16] <= beat_i.data;
				4'd12: code_q.replace[15:0]  <= beat_i.data;
				4'd14: code_q.replace[31:16] <= beat_i.data;
				default: begin
					code_q <= code_q;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Entry complete and table clear pulses
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			strobe_o <= 1'b0;
			clear_o  <= 1'b0;
		end else begin
			// Last word of an entry
			strobe_o <= cheat_wr && (offset == 4'd14);
			// New cartridge or a fresh cheat entry
			clear_o  <= cart_start || (cheat_wr && (offset == 4'd0));
		end
	end

	assign code_o = code_q;

endmodule

`default_nettype wire

/* hdl/md_loader_top.sv */
// Cartridge download pipeline top level
`default_nettype none

module md_loader_top #(
	parameter int ADDR_W = md_loader_pkg::DL_ADDR_W
) (
	input  wire                              clk_sys,
	input  wire                              sys_reset,
	input  wire                              dl_active_i,
	input  wire [7:0]                        dl_index_i,
	input  wire                              dl_wr_i,
	input  wire [ADDR_W-1:0]                 dl_addr_i,
	input  wire [15:0]                       dl_data_i,
	input  wire md_loader_pkg::region_mode_t region_mode_i,
	input  wire md_loader_pkg::region_prio_t region_prio_i,
	output wire                              cart_ms_o,
	output wire md_loader_pkg::region_t      region_o,
	output wire                              region_set_o,
	output wire md_loader_pkg::cheat_code_t  cheat_code_o,
	output wire                              cheat_strobe_o,
	output wire                              cheat_clear_o
);

	md_loader_pkg::dl_beat_t  beat;
	md_loader_pkg::hdr_info_t hdr;

	// Stage 1
	dl_classify #(
		.ADDR_W (ADDR_W)
	) u_classify (
		.clk_sys     (clk_sys),
		.sys_reset   (sys_reset),
		.dl_active_i (dl_active_i),
		.dl_index_i  (dl_index_i),
		.dl_wr_i     (dl_wr_i),
		.dl_addr_i   (dl_addr_i),
		.dl_data_i   (dl_data_i),
		.beat_o      (beat),
		.cart_ms_o   (cart_ms_o)
	);

	// Stage 2
	hdr_region_scan #(
		.ADDR_W (ADDR_W)
	) u_hdr_scan (
		.clk_sys   (clk_sys),
		.sys_reset (sys_reset),
		.beat_i    (beat),
		.hdr_o     (hdr)
	);

	// Stage 3
	region_select u_region_sel (
		.clk_sys       (clk_sys),
		.sys_reset     (sys_reset),
		.hdr_i         (hdr),
		.cart_ms_i     (cart_ms_o),
		.region_mode_i (region_mode_i),
		.region_prio_i (region_prio_i),
		.region_o      (region_o),
		.region_set_o  (region_set_o)
	);

	// Side stage for cheat files
	cheat_code_assembler u_cheat_asm (
		.clk_sys   (clk_sys),
		.sys_reset (sys_reset),
		.beat_i    (beat),
		.code_o    (cheat_code_o),
		.strobe_o  (cheat_strobe_o),
		.clear_o   (cheat_clear_o)
	);

endmodule

`default_nettype wire

/* tests/md_loader_properties.sv */
// Loader output assertions
`default_nettype none

module md_loader_properties (
	input wire       clk_sys,
	input wire       sys_reset,
	input wire       cheat_strobe_o,
	input wire       cheat_clear_o,
	input wire [1:0] region_o,
	input wire       region_set_o
);

	// Entry complete pulse lasts one cycle
	strobe_single_a: assert property (
		@(posedge clk_sys) disable iff (sys_reset)
		cheat_strobe_o |=> !cheat_strobe_o
	) else $error("cheat_strobe_o high for two cycles in a row");

	clear_single_a: assert property (
		@(posedge clk_sys) disable iff (sys_reset)
		cheat_clear_o |=> !cheat_clear_o
	) else $error("cheat_clear_o high for two cycles in a row");

	// Only JP, US and EU are legal codes
	region_legal_a: assert property (
		@(posedge clk_sys) disable iff (sys_reset)
		region_o != 2'd3
	) else $error("region_o holds the unused code 3");

	reset_clears_set_a: assert property (
		@(posedge clk_sys)
		sys_reset |=> !region_set_o
	) else $error("region_set_o high during reset");

endmodule

bind md_loader_top md_loader_properties u_properties (
	.clk_sys        (clk_sys),
	.sys_reset      (sys_reset),
	.cheat_strobe_o (cheat_strobe_o),
	.cheat_clear_o  (cheat_clear_o),
	.region_o       (region_o),
	.region_set_o   (region_set_o)
);

`default_nettype wire

/* tests/tb_md_loader.sv */
// Cartridge loader testbench
`default_nettype none

module tb_md_loader;

	localparam int ADDR_W         = md_loader_pkg::DL_ADDR_W;
	localparam int TIMEOUT_CYCLES = 200;

	logic                         clk_sys;
	logic                         sys_reset;
	logic                         dl_active;
	logic [7:0]                   dl_index;
	logic                         dl_wr;
	logic [ADDR_W-1:0]            dl_addr;
	logic [15:0]                  dl_data;
	md_loader_pkg::region_mode_t  region_mode;
	md_loader_pkg::region_prio_t  region_prio;
	logic                         cart_ms;
	md_loader_pkg::region_t       region;
	logic                         region_set;
	md_loader_pkg::cheat_code_t   cheat_code;
	logic                         cheat_strobe;
	logic                         cheat_clear;

	logic [31:0]                  rng_state;
	md_loader_pkg::region_t       exp_region_q[$];
	md_loader_pkg::cheat_code_t   exp_cheat_q[$];
	int                           clears_expected;
	int                           clears_seen;

	md_loader_top #(
		.ADDR_W (ADDR_W)
	) md_loader_i (
		.clk_sys        (clk_sys),
		.sys_reset      (sys_reset),
		.dl_active_i    (dl_active),
		.dl_index_i     (dl_index),
		.dl_wr_i        (dl_wr),
		.dl_addr_i      (dl_addr),
		.dl_data_i      (dl_data),
		.region_mode_i  (region_mode),
		.region_prio_i  (region_prio),
		.cart_ms_o      (cart_ms),
		.region_o       (region),
		.region_set_o   (region_set),
		.cheat_code_o   (cheat_code),
		.cheat_strobe_o (cheat_strobe),
		.cheat_clear_o  (cheat_clear)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// Region flags as {e, u, j}
	function automatic logic [2:0] letter_flag(input logic [7:0] ch);
		if (ch == "J")
			return 3'b001;
		if (ch == "U")
			return 3'b010;
		if (ch == "E")
			return 3'b100;
		return 3'b000;
	endfunction

	function automatic logic [2:0] header_flags(
		input logic [7:0] lo1,
		input logic [7:0] hi1,
		input logic [7:0] lo2
	);
		logic [2:0] flags;
		logic [7:0] shifted;
		flags   = letter_flag(lo1);
		shifted = lo1 - 8'd7;
		if (flags == 3'b000 && lo1 >= "0" && lo1 <= "9")
			flags = {lo1[3], lo1[2], lo1[0]};
		else if (flags == 3'b000 && lo1 >= "A" && lo1 <= "F")
			flags = {shifted[3], shifted[2], shifted[0]};
		return flags | letter_flag(hi1) | letter_flag(lo2);
	endfunction

	// Flag bit index equals the region code
	function automatic md_loader_pkg::region_t expected_region(
		input md_loader_pkg::region_prio_t prio,
		input logic [2:0]                  flags
	);
		md_loader_pkg::region_t order [3];
		md_loader_pkg::region_t pick;
		case (prio)
			md_loader_pkg::PRIO_US_EU_JP: order = '{md_loader_pkg::REGION_US,
				md_loader_pkg::REGION_EU, md_loader_pkg::REGION_JP};
			md_loader_pkg::PRIO_EU_US_JP: order = '{md_loader_pkg::REGION_EU,
				md_loader_pkg::REGION_US, md_loader_pkg::REGION_JP};
			md_loader_pkg::PRIO_US_JP_EU: order = '{md_loader_pkg::REGION_US,
				md_loader_pkg::REGION_JP, md_loader_pkg::REGION_EU};
			default: order = '{md_loader_pkg::REGION_JP,
				md_loader_pkg::REGION_US, md_loader_pkg::REGION_EU};
		endcase
		pick = order[0];
		for (int i = 2; i >= 0; i--) begin
			if (flags[order[i]])
				pick = order[i];
		end
		return pick;
	endfunction

	function automatic md_loader_pkg::cheat_code_t assemble_cheat(input logic [7:0][15:0] words);
		md_loader_pkg::cheat_code_t code;
		code.flags   = {words[1], words[0]};
		code.addr    = {words[3], words[2]};
		code.compare = {words[5], words[4]};
		code.replace = {words[7], words[6]};
		return code;
	endfunction

	function automatic logic [7:0] region_char(input logic [1:0] sel);
		case (sel)
			2'd0:    return "J";
			2'd1:    return "U";
			2'd2:    return "E";
			default: return " ";
		endcase
	endfunction

	function automatic logic [7:0] hex_char(input int k);
		if (k < 10)
			return 8'("0") + 8'(k);
		return 8'("A") + 8'(k - 10);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Checking
	////////////////////////////////////////////////////////////////////////////

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("sim failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string what, input logic [127:0] got,
		input logic [127:0] expected);
		if (got !== expected)
			fail_run($sformatf("ERROR @%0t: %s is %h, expected %h", $time, what, got, expected));
	endtask

	// Outputs are sampled on the falling edge, away from DUT updates
	initial begin : compare_outputs
		logic                       set_prev;
		md_loader_pkg::region_t     exp_region;
		md_loader_pkg::cheat_code_t exp_code;
		set_prev    = 1'b0;
		clears_seen = 0;
		forever begin
			@(negedge clk_sys);
			if (region_set && !set_prev) begin
				if (exp_region_q.size() == 0) begin
					fail_run("region_set_o rose for a download that should leave it low");
				end else begin
					exp_region = exp_region_q.pop_front();
					check_value("region_o", 128'(region), 128'(exp_region));
				end
			end
			set_prev = region_set;
			if (cheat_strobe) begin
				if (exp_cheat_q.size() == 0) begin
					fail_run("cheat_strobe_o pulsed with no cheat entry pending");
				end else begin
					exp_code = exp_cheat_q.pop_front();
					check_value("cheat_code_o", cheat_code, exp_code);
				end
			end
			if (cheat_clear)
				clears_seen = clears_seen + 1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	task automatic step();
		@(posedge clk_sys);
		#10;
	endtask

	task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [15:0] data);
		dl_wr   = 1'b1;
		dl_addr = addr;
		dl_data = data;
		step();
		dl_wr = 1'b0;
		step();
	endtask

	task automatic wait_regions_done();
		int cycles;
		cycles = 0;
		while (exp_region_q.size() != 0 && cycles < TIMEOUT_CYCLES) begin
			step();
			cycles++;
		end
		if (exp_region_q.size() != 0)
			fail_run("Timeout: region_set_o never rose for the last cartridge");
	endtask

	task automatic wait_set_low();
		int cycles;
		cycles = 0;
		while (region_set && cycles < TIMEOUT_CYCLES) begin
			step();
			cycles++;
		end
		if (region_set)
			fail_run("Timeout: region_set_o stayed high after the download ended");
	endtask

	task automatic wait_cheats_done();
		int cycles;
		cycles = 0;
		while (exp_cheat_q.size() != 0 && cycles < TIMEOUT_CYCLES) begin
			step();
			cycles++;
		end
		if (exp_cheat_q.size() != 0)
			fail_run("Timeout: cheat_strobe_o missing for a cheat entry");
	endtask

	// Cartridge download with an optional region header
	task automatic send_cart(input logic sms, input logic [1:0] ext, input logic with_hdr,
		input logic [7:0] lo1, input logic [7:0] hi1, input logic [7:0] lo2);
		logic [31:0] r;
		logic [2:0]  flags;
		r     = next_random();
		flags = with_hdr ? header_flags(lo1, hi1, lo2) : 3'b000;
		if (!sms && region_mode == md_loader_pkg::RM_HEADER)
			exp_region_q.push_back(expected_region(region_prio, flags));
		else if (!sms && region_mode == md_loader_pkg::RM_FILE_EXT && ext != 2'd0)
			exp_region_q.push_back(md_loader_pkg::region_t'(ext));
		clears_expected = clears_expected + 1;
		dl_index  = {ext, r[0], sms ? 5'd2 : 5'd1};
		dl_active = 1'b1;
		step();
		write_word(ADDR_W'({r[7:1], 1'b0}), r[31:16]);
		write_word(ADDR_W'({r[15:9], 1'b0}), r[23:8]);
		if (with_hdr) begin
			write_word(ADDR_W'(md_loader_pkg::HDR_REGION_ADDR), {hi1, lo1});
			write_word(ADDR_W'(md_loader_pkg::HDR_REGION2_ADDR), {r[15:8], lo2});
		end
		write_word(ADDR_W'(md_loader_pkg::HDR_END_ADDR), r[15:0]);
		for (int k = 1; k <= 3; k++)
			write_word(ADDR_W'(md_loader_pkg::HDR_END_ADDR + 2 * k), r[31:16]);
		dl_active = 1'b0;
		step();
		wait_regions_done();
		wait_set_low();
		check_value("cart_ms_o", 128'(cart_ms), 128'(sms));
	endtask

	task automatic send_cheats(input int entries);
		logic [7:0][15:0] words;
		logic [31:0]      r;
		dl_index  = 8'hFF;
		dl_active = 1'b1;
		step();
		for (int n = 0; n < entries; n++) begin
			for (int w = 0; w < 8; w++) begin
				r        = next_random();
				words[w] = r[15:0];
			end
			exp_cheat_q.push_back(assemble_cheat(words));
			clears_expected = clears_expected + 1;
			for (int w = 0; w < 8; w++)
				write_word(ADDR_W'(n * 16 + w * 2), words[w]);
		end
		dl_active = 1'b0;
		step();
		wait_cheats_done();
	endtask

	initial begin : run_tests
		logic [31:0] r;
		sys_reset       = 1'b1;
		dl_active       = 1'b0;
		dl_index        = 8'h00;
		dl_wr           = 1'b0;
		dl_addr         = '0;
		dl_data         = 16'h0000;
		region_mode     = md_loader_pkg::RM_HEADER;
		region_prio     = md_loader_pkg::PRIO_US_EU_JP;
		rng_state       = 32'he347_043e;
		clears_expected = 0;
		repeat (16) @(posedge clk_sys);
		#10;
		sys_reset = 1'b0;
		check_value("region_set_o after reset", 128'(region_set), 128'(0));
		check_value("cheat_strobe_o after reset", 128'(cheat_strobe), 128'(0));
		check_value("cheat_clear_o after reset", 128'(cheat_clear), 128'(0));
		check_value("cart_ms_o after reset", 128'(cart_ms), 128'(0));
		check_value("region_o after reset", 128'(region), 128'(md_loader_pkg::REGION_JP));

		// Header letters under every priority order
		for (int p = 0; p < 4; p++) begin
			region_prio = md_loader_pkg::region_prio_t'(2'(p));
			for (int k = 0; k < 4; k++) begin
				r = next_random();
				send_cart(1'b0, r[1:0], 1'b1, region_char(r[3:2]), region_char(r[5:4]),
					region_char(r[7:6]));
			end
			send_cart(1'b0, 2'd0, 1'b0, " ", " ", " ");
		end

		// Digits and hex letters
		for (int k = 0; k < 16; k++) begin
			r           = next_random();
			region_prio = md_loader_pkg::region_prio_t'(r[1:0]);
			send_cart(1'b0, r[3:2], 1'b1, hex_char(k), " ", " ");
		end

		region_mode = md_loader_pkg::RM_FILE_EXT;
		for (int k = 0; k < 3; k++)
			send_cart(1'b0, 2'(k), 1'b1, "J", " ", " ");
		region_mode = md_loader_pkg::RM_DISABLED;
		send_cart(1'b0, 2'd1, 1'b1, "U", " ", " ");
		region_mode = md_loader_pkg::RM_DISABLED2;
		send_cart(1'b0, 2'd2, 1'b1, "E", " ", " ");

		// Master System cart, then cheats, then back to Mega Drive
		region_mode = md_loader_pkg::RM_HEADER;
		send_cart(1'b1, 2'd0, 1'b1, "E", " ", " ");
		send_cheats(4);
		send_cart(1'b0, 2'd0, 1'b1, "U", "J", " ");

		check_value("cheat_clear_o pulse count", 128'(clears_seen), 128'(clears_expected));
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
hdl/md_loader_pkg.sv
hdl/dl_classify.sv
hdl/hdr_region_scan.sv
hdl/region_select.sv
hdl/cheat_code_assembler.sv
hdl/md_loader_top.sv
tests/md_loader_properties.sv
tests/tb_md_loader.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the loader testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f build.f \
	--top-module tb_md_loader \
	--Mdir obj_dir \
	-o sim_md_loader

status=0
./obj_dir/sim_md_loader > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "sim failed" sim.log || [ "$status" -ne 0 ]; then
	echo "Simulation reported a failure"
	exit 1
fi

echo "Simulation completed without failures"
